/* files.f */
src/core_pkg.sv
src/alu_unit.sv
src/register_file.sv
src/fetch_unit.sv
src/fetch_queue.sv
src/decode_issue.sv
src/core_top.sv
sim/core_tb.sv

/* run.sh */
#!/usr/bin/env bash
set -e
cd "$(dirname "$0")"

verilator --binary --timing -Wno-fatal --top-module core_tb -f files.f -o core_sim

output=$(./obj_dir/core_sim)
echo "$output"

if grep -qx "all tests passed" <<< "$output"; then
    exit 0
else
    exit 1
fi

/* sim/core_tb.sv */
`timescale 1ns/100ps

module core_tb;
    import core_pkg::*;

    logic clk;
    logic rst_n;
    logic in_valid;
    instr_t in_instr;
    logic in_ready;
    logic retire_valid;
    retire_packet_t retire;
    logic retire_ready;

    // Expected values per data line
    instr_t test_instr [$];
    reg_addr_t exp_rd [$];
    data_t exp_result [$];
    bit exp_illegal [$];

    int errors;
    int retired;
    int cycles;
    int cycle_limit;

    core_top UUT (
        .clk          (clk),
        .rst_n        (rst_n),
        .in_valid     (in_valid),
        .in_instr     (in_instr),
        .in_ready     (in_ready),
        .retire_valid (retire_valid),
        .retire       (retire),
        .retire_ready (retire_ready)
    );

    always #20 clk = ~clk;

    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles >= cycle_limit) begin
            $display("Timeout after %0d cycles with %0d of %0d instructions retired",
                     cycles, retired, test_instr.size());
            $display("tests failed");
            $finish;
        end
    end

    ////////////////////
    // Stimulus file
    task automatic read_vectors();
        int fd;
        int fields;
        string line;
        logic [31:0] word;
        logic [31:0] rd_field;
        logic [31:0] result;
        logic [31:0] illegal;
        fd = $fopen("sim/core_testdata.txt", "r");
        if (fd == 0) begin
            $display("Could not open the stimulus file sim/core_testdata.txt");
            errors++;
        end else begin
            while (!$feof(fd)) begin
                line = "";
                void'($fgets(line, fd));
                // Comment and blank lines yield no fields
                fields = $sscanf(line, "%h %h %h %h", word, rd_field, result, illegal);
                if (fields == 4) begin
                    test_instr.push_back(word);
                    exp_rd.push_back(rd_field[4:0]);
                    exp_result.push_back(result);
                    exp_illegal.push_back(illegal[0]);
                end
            end
            $fclose(fd);
        end
    endtask

    ////////////////////
    // Input stream with random gaps
    task automatic send_all();
        bit accepted;
        for (int idx = 0; idx < test_instr.size(); idx++) begin
            while ($urandom_range(0, 3) == 0) begin
                in_valid <= 1'b0;
                @(posedge clk);
            end
            in_valid <= 1'b1;
            in_instr <= test_instr[idx];
            accepted = 1'b0;
            // Ready seen between edges means the word goes at the next edge
            while (!accepted) begin
                @(negedge clk);
                accepted = in_ready;
                @(posedge clk);
            end
        end
        in_valid <= 1'b0;
    endtask

    task automatic check_packet(input int k);
        pc_t pc_exp;
        instr_id_t id_exp;
        logic wr_exp;
        pc_exp = pc_t'(k * 4);
        id_exp = instr_id_t'(k % 8);
        wr_exp = !exp_illegal[k] && (exp_rd[k] != 5'd0);
        if (retire.pc !== pc_exp) begin
            errors++;
            $display("Mismatch at %0t: packet %0d pc %h, expected %h",
                     $time, k, retire.pc, pc_exp);
        end
        if (retire.id !== id_exp) begin
            errors++;
            $display("Mismatch at %0t: packet %0d id %0d, expected %0d",
                     $time, k, retire.id, id_exp);
        end
        if (retire.rd !== exp_rd[k]) begin
            errors++;
            $display("Mismatch at %0t: packet %0d rd %0d, expected %0d",
                     $time, k, retire.rd, exp_rd[k]);
        end
        if (retire.result !== exp_result[k]) begin
            errors++;
            $display("Mismatch at %0t: packet %0d result %h, expected %h",
                     $time, k, retire.result, exp_result[k]);
        end
        if (retire.wr_en !== wr_exp) begin
            errors++;
            $display("Mismatch at %0t: packet %0d wr_en %b, expected %b",
                     $time, k, retire.wr_en, wr_exp);
        end
        if (retire.illegal !== exp_illegal[k]) begin
            errors++;
            $display("Mismatch at %0t: packet %0d illegal %b, expected %b",
                     $time, k, retire.illegal, exp_illegal[k]);
        end
    endtask

    // Scoreboard in transfer order and the stall hold check
    task automatic collect_retired();
        retire_packet_t held;
        bit holding;
        holding = 1'b0;
        while (retired < test_instr.size()) begin
            @(negedge clk);
            if (holding && (!retire_valid || retire !== held)) begin
                errors++;
                $display("Mismatch at %0t: retire output changed while stalled", $time);
            end
            holding = retire_valid && !retire_ready;
            held = retire;
            if (retire_valid && retire_ready) begin
                check_packet(retired);
                retired++;
            end
        end
    endtask

    ////////////////////
    // Main sequence
    initial begin
        clk = 1'b0;
        rst_n = 1'b0;
        in_valid = 1'b0;
        in_instr = '0;
        retire_ready = 1'b0;
        errors = 0;
        retired = 0;
        cycles = 0;
        cycle_limit = 200;
        void'($urandom(32'hcb2619d0));
        read_vectors();
        cycle_limit = test_instr.size() * 20 + 200;

        repeat (10) @(posedge clk);
        rst_n <= 1'b1;
        @(negedge clk);
        if (!in_ready) begin
            errors++;
            $display("in_ready is low in the first cycle after reset");
        end
        if (retire_valid) begin
            errors++;
            $display("retire_valid is high in the first cycle after reset");
        end
        @(posedge clk);

        // Retire ready is low about a third of the time
        fork
            forever begin
                retire_ready <= ($urandom_range(0, 2) != 0);
                @(posedge clk);
            end
        join_none

        fork
            send_all();
            collect_retired();
        join

        // Anything after the last packet would be a duplicate
        repeat (10) begin
            @(negedge clk);
            if (retire_valid) begin
                errors++;
                $display("An extra packet was retired after the last instruction");
            end
        end

        $display("Errors: %0d, retired %0d of %0d instructions",
                 errors, retired, test_instr.size());
        if (errors == 0)
            $display("all tests passed");
        else
            $display("tests failed");
        $finish;
    end

endmodule

/* sim/core_testdata.txt */
// Columns: instruction word, expected rd, expected result, expected illegal flag
// All values in hex, one instruction per line in issue order
06400093 01 00000064 0
FF900113 02 FFFFFFF9 0
7FF00193 03 000007FF 0
FFF08213 04 00000063 0
FFF12293 05 00000001 0
00513313 06 00000000 0
0FF0C393 07 0000009B 0
8001E413 08 FFFFFFFF 0
0F017493 09 000000F0 0
01809513 0A 64000000 0
00415593 0B 0FFFFFFF 0
40115613 0C FFFFFFFC 0
003086B3 0D 00000863 0
01F41713 0E 80000000 0
405707B3 0F 7FFFFFFF 0
40475833 10 F0000000 0
001128B3 11 00000001 0
00113933 12 00000000 0
003299B3 13 80000000 0
00575A33 14 40000000 0
0013CAB3 15 000000FF 0
0044EB33 16 000000F3 0
008B7BB3 17 000000F3 0
00508013 00 00000069 0
00100C33 18 00000064 0
00012083 01 00000000 1
FFFFFFFF 1F 00000000 1
00008C93 19 00000064 0
40408D33 1A 00000001 0

/* src/alu_unit.sv */
`timescale 1ns/100ps

module alu_unit (
    input  core_pkg::alu_inputs_t alu_in,
    output core_pkg::data_t       result
);
    import core_pkg::*;

    logic [4:0] shamt;

    // Shifts only ever look at the low five bits
    assign shamt = alu_in.op_b[4:0];

    always_comb begin
        case (alu_in.op)
            alu_add:
                result = alu_in.op_a + alu_in.op_b;
            alu_sub:
                result = alu_in.op_a - alu_in.op_b;
            alu_sll:
                result = alu_in.op_a << shamt;
            alu_slt:
                result = data_t'($signed(alu_in.op_a) < $signed(alu_in.op_b));
            alu_sltu:
                result = data_t'(alu_in.op_a < alu_in.op_b);
            alu_xor:
                result = alu_in.op_a ^ alu_in.op_b;
            alu_srl:
                result = alu_in.op_a >> shamt;
            // Sign bit fills from the left
            alu_sra:
                result = data_t'($signed(alu_in.op_a) >>> shamt);
            alu_or:
                result = alu_in.op_a | alu_in.op_b;
            alu_and:
                result = alu_in.op_a & alu_in.op_b;
            default:
                result = '0;
        endcase
    end

endmodule

/* src/core_pkg.sv */
package core_pkg;

    ////////////////////
    // Core dimensions
    localparam int xlen = 32;
    localparam int reg_count = 32;
    localparam int queue_depth = 4;
    localparam logic [31:0] reset_pc = 32'h0000_0000;
    localparam int pc_step = 4;
    localparam int id_width = 3;

    typedef logic [xlen-1:0] data_t;
    typedef logic [31:0] instr_t;
    typedef logic [31:0] pc_t;
    typedef logic [4:0] reg_addr_t;
    // Wraps after seven
    typedef logic [id_width-1:0] instr_id_t;

    ////////////////////
    // Encodings
    // Any opcode other than these two is illegal
    typedef enum logic [6:0] {
        opcode_op     = 7'b0110011,
        opcode_op_imm = 7'b0010011
    } opcode_t;

    typedef enum logic [3:0] {
        alu_add,
        alu_sub,
        alu_sll,
        alu_slt,
        alu_sltu,
        alu_xor,
        alu_srl,
        alu_sra,
        alu_or,
        alu_and
    } alu_op_t;

    ////////////////////
    // Stage packets
    typedef struct packed {
        instr_t instr;
        pc_t pc;
        instr_id_t id;
    } fetch_packet_t;

    typedef struct packed {
        data_t op_a;
        data_t op_b;
        alu_op_t op;
    } alu_inputs_t;

    typedef struct packed {
        pc_t pc;
        instr_id_t id;
        reg_addr_t rd;
        data_t result;
        logic wr_en;
        logic illegal;
    } retire_packet_t;

endpackage

/* src/core_top.sv */
`timescale 1ns/100ps

module core_top (
    input  logic                     clk,
    input  logic                     rst_n,

    input  logic                     in_valid,
    input  core_pkg::instr_t         in_instr,
    output logic                     in_ready,

    output logic                     retire_valid,
    output core_pkg::retire_packet_t retire,
    input  logic                     retire_ready
);
    import core_pkg::*;

    // Fetch register to queue
    logic fetch_valid;
    logic fetch_ready;
    fetch_packet_t fetch;

    // Queue head to decode
    logic issue_valid;
    logic issue_ready;
    fetch_packet_t issue;

    ////////////////////
    // Pipeline stages
    fetch_unit fetch_block (
        .clk         (clk),
        .rst_n       (rst_n),
        .in_valid    (in_valid),
        .in_instr    (in_instr),
        .in_ready    (in_ready),
        .fetch_valid (fetch_valid),
        .fetch       (fetch),
        .fetch_ready (fetch_ready)
    );

    fetch_queue queue_block (
        .clk         (clk),
        .rst_n       (rst_n),
        .fetch_valid (fetch_valid),
        .fetch       (fetch),
        .fetch_ready (fetch_ready),
        .issue_valid (issue_valid),
        .issue       (issue),
        .issue_ready (issue_ready)
    );

    decode_issue decode_block (
        .clk          (clk),
        .rst_n        (rst_n),
        .issue_valid  (issue_valid),
        .issue        (issue),
        .issue_ready  (issue_ready),
        .retire_valid (retire_valid),
        .retire       (retire),
        .retire_ready (retire_ready)
    );

endmodule

/* src/decode_issue.sv */
`timescale 1ns/100ps

module decode_issue (
    input  logic                     clk,
    input  logic                     rst_n,

    input  logic                     issue_valid,
    input  core_pkg::fetch_packet_t  issue,
    output logic                     issue_ready,

    output logic                     retire_valid,
    output core_pkg::retire_packet_t retire,
    input  logic                     retire_ready
);
    import core_pkg::*;

    opcode_t opcode;
    reg_addr_t rd;
    reg_addr_t rs1;
    reg_addr_t rs2;
    logic [2:0] funct3;
    logic [6:0] funct7;
    data_t imm;
    data_t rs1_data;
    data_t rs2_data;
    alu_inputs_t alu_in;
    data_t alu_result;
    logic legal;
    logic is_reg;
    logic take;
    logic wr_en;

    ////////////////////
    // Field split
    assign opcode = opcode_t'(issue.instr[6:0]);
    assign rd = issue.instr[11:7];
    assign funct3 = issue.instr[14:12];
    assign rs1 = issue.instr[19:15];
    assign rs2 = issue.instr[24:20];
    assign funct7 = issue.instr[31:25];
    assign imm = data_t'($signed(issue.instr[31:20]));

    assign is_reg = (opcode == opcode_op);
    assign legal = is_reg || (opcode == opcode_op_imm);

    // Operand select and operation
    always_comb begin
        alu_in.op_a = rs1_data;
        // Shift amounts sit in the low immediate bits
        if (is_reg)
            alu_in.op_b = rs2_data;
        else
            alu_in.op_b = imm;
        case (funct3)
            3'b000: alu_in.op = (is_reg && funct7[5]) ? alu_sub : alu_add;
            3'b001: alu_in.op = alu_sll;
            3'b010: alu_in.op = alu_slt;
            3'b011: alu_in.op = alu_sltu;
            3'b100: alu_in.op = alu_xor;
            3'b101: alu_in.op = funct7[5] ? alu_sra : alu_srl;
            3'b110: alu_in.op = alu_or;
            default: alu_in.op = alu_and;
        endcase
    end

    ////////////////////
    // Issue and writeback
    assign issue_ready = !retire_valid || retire_ready;
    assign take = issue_valid && issue_ready;
    assign wr_en = take && legal && (rd != '0);

    register_file regfile_block (
        .clk      (clk),
        .rst_n    (rst_n),
        .rs1_addr (rs1),
        .rs2_addr (rs2),
        .rs1_data (rs1_data),
        .rs2_data (rs2_data),
        .wr_en    (wr_en),
        .wr_addr  (rd),
        .wr_data  (alu_result)
    );

    alu_unit alu_block (
        .alu_in (alu_in),
        .result (alu_result)
    );

    // Retire register
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n)
            retire_valid <= 1'b0;
        else if (take)
            retire_valid <= 1'b1;
        else if (retire_ready)
            retire_valid <= 1'b0;
    end

    always_ff @(posedge clk) begin
        if (take) begin
            retire.pc <= issue.pc;
            retire.id <= issue.id;
            retire.rd <= rd;
            retire.result <= legal ? alu_result : '0;
            retire.wr_en <= legal && (rd != '0);
            retire.illegal <= !legal;
        end
    end

endmodule

/* src/fetch_queue.sv */
`timescale 1ns/100ps

module fetch_queue (
    input  logic                    clk,
    input  logic                    rst_n,

    input  logic                    fetch_valid,
    input  core_pkg::fetch_packet_t fetch,
    output logic                    fetch_ready,

    output logic                    issue_valid,
    output core_pkg::fetch_packet_t issue,
    input  logic                    issue_ready
);
    import core_pkg::*;

    fetch_packet_t entries [queue_depth];
    logic [$clog2(queue_depth)-1:0] rd_ptr;
    logic [$clog2(queue_depth)-1:0] wr_ptr;
    logic [$clog2(queue_depth+1)-1:0] count;
    logic full;
    logic wr_en;
    logic rd_en;

    assign full = (int'(count) == queue_depth);

    // Head is visible as soon as anything is stored
    assign issue_valid = (count != '0);
    assign issue = entries[rd_ptr];

    // A full queue still accepts when the head leaves
    assign fetch_ready = !full || issue_ready;

    assign wr_en = fetch_valid && fetch_ready;
    assign rd_en = issue_valid && issue_ready;

    ////////////////////
    // Pointers and occupancy
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            rd_ptr <= '0;
            wr_ptr <= '0;
            count <= '0;
        end else begin
            if (wr_en)
                wr_ptr <= wr_ptr + 1'b1;
            if (rd_en)
                rd_ptr <= rd_ptr + 1'b1;
            case ({wr_en, rd_en})
                2'b10: count <= count + 1'b1;
                2'b01: count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

    // Storage
    always_ff @(posedge clk) begin
        if (wr_en)
            entries[wr_ptr] <= fetch;
    end

endmodule

/* src/fetch_unit.sv */
`timescale 1ns/100ps

module fetch_unit (
    input  logic                    clk,
    input  logic                    rst_n,

    input  logic                    in_valid,
    input  core_pkg::instr_t        in_instr,
    output logic                    in_ready,

    output logic                    fetch_valid,
    output core_pkg::fetch_packet_t fetch,
    input  logic                    fetch_ready
);
    import core_pkg::*;

    pc_t next_pc;
    instr_id_t next_id;
    logic accept;

    // Register is free when empty or draining this cycle
    assign in_ready = !fetch_valid || fetch_ready;
    assign accept = in_valid && in_ready;

    ////////////////////
    // Tag counters and valid flag
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            fetch_valid <= 1'b0;
            next_pc <= reset_pc;
            next_id <= '0;
        end else begin
            if (accept) begin
                fetch_valid <= 1'b1;
                next_pc <= next_pc + pc_t'(pc_step);
                next_id <= next_id + instr_id_t'(1);
            end else if (fetch_ready) begin
                fetch_valid <= 1'b0;
            end
        end
    end

    // Payload loads only on acceptance
    always_ff @(posedge clk) begin
        if (accept) begin
            fetch.instr <= in_instr;
            fetch.pc <= next_pc;
            fetch.id <= next_id;
        end
    end

endmodule

/* src/register_file.sv */
`timescale 1ns/100ps

module register_file (
    input  logic                clk,
    input  logic                rst_n,

    input  core_pkg::reg_addr_t rs1_addr,
    input  core_pkg::reg_addr_t rs2_addr,
    output core_pkg::data_t     rs1_data,
    output core_pkg::data_t     rs2_data,

    input  logic                wr_en,
    input  core_pkg::reg_addr_t wr_addr,
    input  core_pkg::data_t     wr_data
);
    import core_pkg::*;

    data_t regs [reg_count];

    // Write port skips x0
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            for (int i = 0; i < reg_count; i++)
                regs[i] <= '0;
        end else if (wr_en && wr_addr != '0) begin
            regs[wr_addr] <= wr_data;
        end
    end

    // Asynchronous read ports
    assign rs1_data = (rs1_addr == '0) ? '0 : regs[rs1_addr];
    assign rs2_data = (rs2_addr == '0) ? '0 : regs[rs2_addr];

endmodule
